/* vlog.f */
logic/pcxt_support_pkg.sv
logic/reset_sequencer.sv
logic/bios_loader.sv
logic/clock_enables.sv
logic/audio_output.sv
logic/pcxt_support_top.sv
verif/tb_pcxt_support.sv

/* verif/tb_pcxt_support.sv */
// directed testbench for the pc/xt board-support top level
// memory model acks each wishbone write after 0 to 3 clocks
// inputs change on the falling edge and outputs are sampled there too
// the last test resets the dut again so the dac starts from zero
`timescale 1ns/10ps

module tb_pcxt_support;

	localparam int CLK_PERIOD = 100;
	localparam int STRETCH = pcxt_support_pkg::RESET_STRETCH_CYCLES;
	localparam int CPU_DELAY = pcxt_support_pkg::CPU_RESET_DELAY;
	localparam int DL_BYTES = 8;
	localparam int WAIT_LIMIT = 32;
	localparam int CEN_DRIVE_CLKS = 120;
	localparam int CEN_CLKS = 130;
	localparam int DAC_CLKS = 4096;

	// test lengths in clocks, ack delays included
	localparam int RESET_CLKS = 2 * (STRETCH + CPU_DELAY) + 20;
	localparam int DL_CLKS = DL_BYTES * 12 + 10;
	localparam int WATCHDOG_CLKS = RESET_CLKS + 50 + 3 * DL_CLKS + 50 + 20
		+ CEN_CLKS + 10 + DAC_CLKS + 200;

	logic                            clk_chipset = 1'b0;
	logic                            reset;
	pcxt_support_pkg::board_cfg_t    cfg;
	pcxt_support_pkg::dl_port_t      dl;
	logic                            dl_wait;
	logic                            mem_ready;
	logic                            bus_grant;
	logic                            bus_req;
	pcxt_support_pkg::wb_m2s_t       wb;
	logic                            wb_ack;
	logic                            biu_done;
	logic                            opl2_clk;
	logic                            uart_clk;
	pcxt_support_pkg::opl_sample_t   opl;
	pcxt_support_pkg::tandy_sample_t tandy;
	logic                            speaker;
	logic                            sys_reset;
	logic                            cpu_reset;
	logic                            bios_protect;
	logic                            tandy_flag;
	pcxt_support_pkg::speed_t        speed;
	logic                            turbo;
	logic                            cen_opl2;
	logic                            cen_uart;
	pcxt_support_pkg::mix_t          mix;
	logic                            audio;

	// bookkeeping
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_err_start = 0;
	logic        model_exp;

	// captured bus cycles
	pcxt_support_pkg::mem_addr_t cyc_adr_q[$];
	pcxt_support_pkg::mem_data_t cyc_dat_q[$];
	logic                        cyc_flag_q[$];
	int                          ack_wait = 0;
	bit                          in_cycle = 1'b0;

	pcxt_support_top u_dut (
		.clk_chipset    (clk_chipset),
		.reset          (reset),
		.cfg_i          (cfg),
		.dl_i           (dl),
		.dl_wait_o      (dl_wait),
		.mem_ready_i    (mem_ready),
		.bus_grant_i    (bus_grant),
		.bus_req_o      (bus_req),
		.wb_o           (wb),
		.wb_ack_i       (wb_ack),
		.biu_done_i     (biu_done),
		.opl2_clk_i     (opl2_clk),
		.uart_clk_i     (uart_clk),
		.opl_i          (opl),
		.tandy_i        (tandy),
		.speaker_i      (speaker),
		.sys_reset_o    (sys_reset),
		.cpu_reset_o    (cpu_reset),
		.bios_protect_o (bios_protect),
		.tandy_flag_o   (tandy_flag),
		.speed_o        (speed),
		.turbo_o        (turbo),
		.cen_opl2_o     (cen_opl2),
		.cen_uart_o     (cen_uart),
		.mix_o          (mix),
		.audio_o        (audio)
	);

	initial begin
		forever begin
			#(CLK_PERIOD / 2) clk_chipset = 1'b1;
			#(CLK_PERIOD / 2) clk_chipset = 1'b0;
		end
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic report_error(string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic check_addr(string name, pcxt_support_pkg::mem_addr_t got,
		pcxt_support_pkg::mem_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_data(string name, pcxt_support_pkg::mem_data_t got,
		pcxt_support_pkg::mem_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_speed(string name, pcxt_support_pkg::speed_t got,
		pcxt_support_pkg::speed_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_mix(string name, pcxt_support_pkg::mix_t got,
		pcxt_support_pkg::mix_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	// counts, tol is the allowed distance
	task automatic check_count(string name, int got, int exp, int tol);
		checks++;
		if (got > exp + tol || got < exp - tol) begin
			errors++;
			$display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic finish_test(string name);
		tests++;
		$display("test %s done, %0d errors", name, errors - test_err_start);
		test_err_start = errors;
	endtask

	////////////////////
	// reference rules
	////////////////////

	// bios map, ec00 window for index 3, top 64k otherwise
	function automatic pcxt_support_pkg::mem_addr_t expected_addr(
		pcxt_support_pkg::dl_index_t idx, pcxt_support_pkg::dl_addr_t off);
		if (idx == pcxt_support_pkg::IDX_XTIDE) begin
			return {pcxt_support_pkg::XTIDE_BASE, off[13:0]};
		end else begin
			return {pcxt_support_pkg::BIOS_SEG_BASE, off[15:0]};
		end
	endfunction

	// signed opl2, 2^14 for a low speaker bit, tandy times 512, wraps at 17 bits
	function automatic pcxt_support_pkg::mix_t expected_mix(
		pcxt_support_pkg::opl_sample_t o, pcxt_support_pkg::tandy_sample_t t, logic s);
		int sum;
		sum = o;
		sum = sum + (s ? 0 : 16384) + int'(t) * 512;
		return pcxt_support_pkg::mix_t'(sum);
	endfunction

	////////////////////
	// memory model
	////////////////////

	// wishbone slave, random ack delay per cycle
	always @(negedge clk_chipset) begin
		if (wb_ack) begin
			// master dropped cyc on the ack edge
			wb_ack = 1'b0;
		end else if (wb.cyc && wb.stb) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				ack_wait = $urandom % 4;
			end
			if (ack_wait == 0) begin
				if (!wb.we) begin
					report_error("wishbone cycle without write enable");
				end
				cyc_adr_q.push_back(wb.adr);
				cyc_dat_q.push_back(wb.dat);
				cyc_flag_q.push_back(tandy_flag);
				wb_ack = 1'b1;
				in_cycle = 1'b0;
			end else begin
				ack_wait--;
			end
		end
	end

	////////////////////
	// download helpers
	////////////////////

	task automatic pulse_wr(pcxt_support_pkg::dl_index_t idx,
		pcxt_support_pkg::dl_addr_t off, pcxt_support_pkg::mem_data_t data);
		dl.index = idx;
		dl.addr = off;
		dl.data = data;
		dl.wr = 1'b1;
		@(negedge clk_chipset);
		dl.wr = 1'b0;
	endtask

	task automatic wait_ready(string what);
		int n;
		n = 0;
		while (dl_wait && n < WAIT_LIMIT) begin
			@(negedge clk_chipset);
			n++;
		end
		if (dl_wait) begin
			report_error($sformatf("dl_wait_o stuck high for %0d clocks (%s)", n, what));
		end
	endtask

	task automatic send_byte(pcxt_support_pkg::dl_index_t idx,
		pcxt_support_pkg::dl_addr_t off, pcxt_support_pkg::mem_data_t data);
		pulse_wr(idx, off, data);
		wait_ready("byte write");
	endtask

	// exactly one bus cycle since the last call
	task automatic check_one_cycle(pcxt_support_pkg::dl_index_t idx,
		pcxt_support_pkg::dl_addr_t off, pcxt_support_pkg::mem_data_t data);
		if (cyc_adr_q.size() != 1) begin
			report_error($sformatf("expected one wishbone cycle, saw %0d", cyc_adr_q.size()));
			cyc_adr_q.delete();
			cyc_dat_q.delete();
			cyc_flag_q.delete();
		end else begin
			check_addr("wb_o.adr", cyc_adr_q.pop_front(), expected_addr(idx, off));
			check_data("wb_o.dat", cyc_dat_q.pop_front(), data);
			check_flag("tandy_flag_o in cycle", cyc_flag_q.pop_front(),
				idx == pcxt_support_pkg::IDX_TANDY);
		end
	endtask

	task automatic start_download();
		dl.active = 1'b1;
		dl.wr = 1'b0;
		@(negedge clk_chipset);
		wait_ready("download start");
		check_flag("bios_protect_o", bios_protect, 1'b0);
		check_flag("bus_req_o", bus_req, 1'b1);
	endtask

	task automatic end_download();
		dl.active = 1'b0;
		repeat (3) @(negedge clk_chipset);
		check_flag("bios_protect_o", bios_protect, 1'b1);
		check_flag("bus_req_o", bus_req, 1'b0);
		check_flag("dl_wait_o", dl_wait, 1'b0);
	endtask

	// bus not fully available, byte must be held off
	task automatic try_blocked(logic grant, logic ready);
		bus_grant = grant;
		mem_ready = ready;
		repeat (2) @(negedge clk_chipset);
		check_flag("bus_req_o", bus_req, 1'b1);
		check_flag("dl_wait_o", dl_wait, 1'b1);
		check_flag("bios_protect_o", bios_protect, 1'b1);
		pulse_wr(8'd0, 25'h000123, 8'h5a);
		repeat (3) @(negedge clk_chipset);
		check_count("wishbone cycles", cyc_adr_q.size(), 0, 0);
	endtask

	// unmapped byte, one wait clock and no cycle
	task automatic drop_byte(pcxt_support_pkg::dl_index_t idx,
		pcxt_support_pkg::dl_addr_t off, pcxt_support_pkg::mem_data_t data);
		pulse_wr(idx, off, data);
		check_flag("dl_wait_o", dl_wait, 1'b1);
		@(negedge clk_chipset);
		check_flag("dl_wait_o", dl_wait, 1'b0);
		repeat (3) @(negedge clk_chipset);
		check_count("wishbone cycles", cyc_adr_q.size(), 0, 0);
	endtask

	////////////////////
	// tests
	////////////////////

	// counts edges until each reset output falls
	task automatic check_reset_release();
		int n;
		n = 0;
		while (sys_reset && n <= 2 * STRETCH) begin
			@(negedge clk_chipset);
			n++;
		end
		check_count("sys_reset_o release clocks", n, STRETCH, 0);
		n = 0;
		while (cpu_reset && n <= 2 * CPU_DELAY) begin
			@(negedge clk_chipset);
			n++;
		end
		check_count("cpu_reset_o release clocks", n, CPU_DELAY, 0);
	endtask

	task automatic reset_timing();
		repeat (3) @(negedge clk_chipset);
		// everything idle while reset is held
		check_flag("sys_reset_o", sys_reset, 1'b1);
		check_flag("cpu_reset_o", cpu_reset, 1'b1);
		check_flag("bus_req_o", bus_req, 1'b0);
		check_flag("dl_wait_o", dl_wait, 1'b0);
		check_flag("wb_o.cyc", wb.cyc, 1'b0);
		check_flag("wb_o.stb", wb.stb, 1'b0);
		check_flag("wb_o.we", wb.we, 1'b0);
		check_flag("bios_protect_o", bios_protect, 1'b1);
		check_flag("cen_opl2_o", cen_opl2, 1'b0);
		check_flag("cen_uart_o", cen_uart, 1'b0);
		check_speed("speed_o", speed, pcxt_support_pkg::SPEED_4_77);
		check_flag("turbo_o", turbo, 1'b0);
		check_flag("audio_o", audio, 1'b0);
		check_mix("mix_o", mix, '0);
		reset = 1'b0;
		check_reset_release();
		check_flag("tandy_flag_o", tandy_flag, 1'b0);
		// menu reset with the tandy model selected
		cfg.reset_req = 1'b1;
		cfg.model_tandy = 1'b1;
		@(negedge clk_chipset);
		cfg.reset_req = 1'b0;
		check_flag("sys_reset_o", sys_reset, 1'b1);
		check_flag("cpu_reset_o", cpu_reset, 1'b1);
		check_reset_release();
		model_exp = 1'b1;
		check_flag("tandy_flag_o", tandy_flag, model_exp);
		// model change outside reset is ignored
		cfg.model_tandy = 1'b0;
		repeat (4) @(negedge clk_chipset);
		check_flag("tandy_flag_o", tandy_flag, model_exp);
		finish_test("reset timing");
	endtask

	task automatic bus_conditions();
		dl.active = 1'b1;
		try_blocked(1'b0, 1'b0);
		try_blocked(1'b1, 1'b0);
		try_blocked(1'b0, 1'b1);
		bus_grant = 1'b1;
		mem_ready = 1'b1;
		@(negedge clk_chipset);
		wait_ready("grant and ready");
		check_flag("bios_protect_o", bios_protect, 1'b0);
		// first byte after the grant goes through
		send_byte(8'd0, 25'h00abcd, 8'hc3);
		check_one_cycle(8'd0, 25'h00abcd, 8'hc3);
		end_download();
		finish_test("bus conditions");
	endtask

	task automatic bios_download(pcxt_support_pkg::dl_index_t idx);
		pcxt_support_pkg::dl_addr_t  off;
		pcxt_support_pkg::mem_data_t data;
		int                          i;
		start_download();
		for (i = 0; i < DL_BYTES; i++) begin
			off = pcxt_support_pkg::dl_addr_t'($urandom % 65536);
			data = pcxt_support_pkg::mem_data_t'($urandom);
			send_byte(idx, off, data);
			check_one_cycle(idx, off, data);
			// between cycles the flag shows the model
			check_flag("tandy_flag_o", tandy_flag, model_exp);
			check_flag("bios_protect_o", bios_protect, 1'b0);
		end
		end_download();
		finish_test($sformatf("download index %0d", idx));
	endtask

	task automatic ignored_bytes();
		start_download();
		drop_byte(8'd5, 25'h000100, 8'h11);
		drop_byte(8'd0, 25'h012345, 8'h22);
		drop_byte(pcxt_support_pkg::IDX_TANDY, 25'h1000000, 8'h33);
		// loader still armed afterwards
		send_byte(pcxt_support_pkg::IDX_PCXT_LAST, 25'h00fff0, 8'ha5);
		check_one_cycle(pcxt_support_pkg::IDX_PCXT_LAST, 25'h00fff0, 8'ha5);
		end_download();
		finish_test("ignored bytes");
	endtask

	task automatic speed_latch();
		pcxt_support_pkg::speed_t code;
		pcxt_support_pkg::speed_t exp_speed;
		logic                     exp_turbo;
		int                       i;
		exp_speed = pcxt_support_pkg::SPEED_4_77;
		exp_turbo = 1'b0;
		// codes 1, 2, 3, 0
		for (i = 1; i <= 4; i++) begin
			code = pcxt_support_pkg::speed_t'(i % 4);
			cfg.cpu_speed = code;
			repeat (3) @(negedge clk_chipset);
			check_speed("speed_o", speed, exp_speed);
			check_flag("turbo_o", turbo, exp_turbo);
			biu_done = 1'b1;
			@(negedge clk_chipset);
			biu_done = 1'b0;
			exp_turbo = (code == pcxt_support_pkg::SPEED_7_16)
				|| (code == pcxt_support_pkg::SPEED_14_318);
			exp_speed = exp_turbo ? code : pcxt_support_pkg::SPEED_4_77;
			check_speed("speed_o", speed, exp_speed);
			check_flag("turbo_o", turbo, exp_turbo);
		end
		finish_test("speed latch");
	endtask

	task automatic clock_enable_pulses();
		int   t;
		int   opl_edges;
		int   uart_edges;
		int   opl_pulses;
		int   uart_pulses;
		logic opl_prev;
		logic uart_prev;
		logic next_opl;
		logic next_uart;
		opl_edges = 0;
		uart_edges = 0;
		opl_pulses = 0;
		uart_pulses = 0;
		opl_prev = 1'b0;
		uart_prev = 1'b0;
		for (t = 0; t < CEN_CLKS; t++) begin
			@(negedge clk_chipset);
			if (cen_opl2) begin
				if (opl_prev) report_error("cen_opl2_o high for more than one clock");
				opl_pulses++;
			end
			if (cen_uart) begin
				if (uart_prev) report_error("cen_uart_o high for more than one clock");
				uart_pulses++;
			end
			opl_prev = cen_opl2;
			uart_prev = cen_uart;
			// phases of 3 and 4 clocks, then quiet
			next_opl = (t < CEN_DRIVE_CLKS) && ((t / 3) % 2 == 1);
			next_uart = (t < CEN_DRIVE_CLKS) && ((t / 4) % 2 == 1);
			if (next_opl && !opl2_clk) opl_edges++;
			if (next_uart && !uart_clk) uart_edges++;
			opl2_clk = next_opl;
			uart_clk = next_uart;
		end
		check_count("cen_opl2_o pulses", opl_pulses, opl_edges, 0);
		check_count("cen_uart_o pulses", uart_pulses, uart_edges, 0);
		finish_test("clock enables");
	endtask

	task automatic apply_mix(pcxt_support_pkg::opl_sample_t o,
		pcxt_support_pkg::tandy_sample_t t, logic s);
		opl = o;
		tandy = t;
		speaker = s;
		@(negedge clk_chipset);
		check_mix("mix_o", mix, expected_mix(o, t, s));
	endtask

	task automatic audio_mix();
		int i;
		apply_mix(16'h0000, 8'h00, 1'b1);
		apply_mix(16'h8000, 8'h00, 1'b0);
		apply_mix(16'h7fff, 8'hff, 1'b0);
		apply_mix(16'hff00, 8'h80, 1'b1);
		for (i = 0; i < 4; i++) begin
			apply_mix($urandom, $urandom, $urandom % 2);
		end
		finish_test("audio mix");
	endtask

	// pulse density from a fresh accumulator
	task automatic dac_density();
		pcxt_support_pkg::mix_t m;
		logic [15:0]            code;
		int                     ones;
		int                     i;
		opl = 16'h1234;
		tandy = 8'h40;
		speaker = 1'b1;
		m = expected_mix(opl, tandy, speaker);
		// offset binary of the upper 16 mix bits
		code = m[16:1] ^ 16'h8000;
		reset = 1'b1;
		repeat (3) @(negedge clk_chipset);
		reset = 1'b0;
		ones = 0;
		for (i = 0; i < DAC_CLKS; i++) begin
			@(negedge clk_chipset);
			if (audio) ones++;
		end
		check_count("audio_o ones", ones, (DAC_CLKS * int'(code)) / 65536, 1);
		finish_test("dac density");
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		void'($urandom(44));
		reset = 1'b1;
		cfg = '0;
		dl = '0;
		mem_ready = 1'b0;
		bus_grant = 1'b0;
		wb_ack = 1'b0;
		biu_done = 1'b0;
		opl2_clk = 1'b0;
		uart_clk = 1'b0;
		opl = '0;
		tandy = '0;
		speaker = 1'b1;
		model_exp = 1'b0;
		reset_timing();
		bus_conditions();
		bios_download(8'd0);
		bios_download(pcxt_support_pkg::IDX_TANDY);
		bios_download(pcxt_support_pkg::IDX_XTIDE);
		ignored_bytes();
		speed_latch();
		clock_enable_pulses();
		audio_mix();
		dac_density();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog over the summed test lengths
	initial begin
		#(WATCHDOG_CLKS * CLK_PERIOD);
		$display("timeout: run did not finish within %0d clocks", WATCHDOG_CLKS);
		$display("Regression failed");
		$finish;
	end

endmodule

/* logic/pcxt_support_top.sv */
// board-support logic around the 8088 pc/xt core
// everything runs on clk_chipset, slow clocks arrive asynchronous
// rom writes leave as wishbone classic cycles to the memory side
`timescale 1ns/10ps

module pcxt_support_top (
	input  logic                            clk_chipset,
	input  logic                            reset,
	input  pcxt_support_pkg::board_cfg_t    cfg_i,
	// rom download
	input  pcxt_support_pkg::dl_port_t      dl_i,
	output logic                            dl_wait_o,
	input  logic                            mem_ready_i,
	input  logic                            bus_grant_i,
	output logic                            bus_req_o,
	// memory writes
	output pcxt_support_pkg::wb_m2s_t       wb_o,
	input  logic                            wb_ack_i,
	// clocking
	input  logic                            biu_done_i,
	input  logic                            opl2_clk_i,
	input  logic                            uart_clk_i,
	// sound sources
	input  pcxt_support_pkg::opl_sample_t   opl_i,
	input  pcxt_support_pkg::tandy_sample_t tandy_i,
	input  logic                            speaker_i,
	// to the core
	output logic                            sys_reset_o,
	output logic                            cpu_reset_o,
	output logic                            bios_protect_o,
	output logic                            tandy_flag_o,
	output pcxt_support_pkg::speed_t        speed_o,
	output logic                            turbo_o,
	output logic                            cen_opl2_o,
	output logic                            cen_uart_o,
	output pcxt_support_pkg::mix_t          mix_o,
	output logic                            audio_o
);

	// latched machine model
	logic model_tandy;

	reset_sequencer u_reset_sequencer (
		.clk_chipset   (clk_chipset),
		.reset         (reset),
		.cfg_i         (cfg_i),
		.sys_reset_o   (sys_reset_o),
		.cpu_reset_o   (cpu_reset_o),
		.model_tandy_o (model_tandy)
	);

	bios_loader u_bios_loader (
		.clk_chipset    (clk_chipset),
		.reset          (reset),
		.sys_reset_i    (sys_reset_o),
		.dl_i           (dl_i),
		.dl_wait_o      (dl_wait_o),
		.mem_ready_i    (mem_ready_i),
		.bus_grant_i    (bus_grant_i),
		.bus_req_o      (bus_req_o),
		.wb_o           (wb_o),
		.wb_ack_i       (wb_ack_i),
		.model_tandy_i  (model_tandy),
		.bios_protect_o (bios_protect_o),
		.tandy_flag_o   (tandy_flag_o)
	);

	// speed comes straight from the menu, latched inside
	clock_enables u_clock_enables (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.biu_done_i  (biu_done_i),
		.speed_sel_i (cfg_i.cpu_speed),
		.opl2_clk_i  (opl2_clk_i),
		.uart_clk_i  (uart_clk_i),
		.speed_o     (speed_o),
		.turbo_o     (turbo_o),
		.cen_opl2_o  (cen_opl2_o),
		.cen_uart_o  (cen_uart_o)
	);

	audio_output u_audio_output (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.opl_i       (opl_i),
		.tandy_i     (tandy_i),
		.speaker_i   (speaker_i),
		.mix_o       (mix_o),
		.audio_o     (audio_o)
	);

endmodule

/* logic/audio_output.sv */
// sound mixer and first-order sigma-delta dac
// one bitstream feeds both channels
// mix can wrap for loud opl2 output together with a loud tandy byte
`timescale 1ns/10ps

module audio_output (
	input  logic                            clk_chipset,
	input  logic                            reset,
	input  pcxt_support_pkg::opl_sample_t   opl_i,
	input  pcxt_support_pkg::tandy_sample_t tandy_i,
	input  logic                            speaker_i,
	output pcxt_support_pkg::mix_t          mix_o,
	output logic                            audio_o
);

	// mixer terms at 17 bits
	pcxt_support_pkg::mix_t opl_ext;
	pcxt_support_pkg::mix_t spk_term;
	pcxt_support_pkg::mix_t tandy_term;

	// dac code and accumulator
	logic [15:0] dac_code;
	logic [15:0] acc;
	logic [16:0] acc_sum;

	////////////////////
	// mixer
	////////////////////

	// opl2 is signed, sign extend
	assign opl_ext = {opl_i[15], opl_i};
	// speaker adds its level when the bit is low
	assign spk_term = speaker_i ? '0 : pcxt_support_pkg::SPEAKER_LEVEL;
	// tandy byte weighted by 512
	assign tandy_term = {tandy_i, 9'd0};

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			mix_o <= '0;
		end else begin
			mix_o <= opl_ext + spk_term + tandy_term;
		end
	end

	////////////////////
	// sigma-delta
	////////////////////

	// offset binary, zero mix sits at mid scale
	assign dac_code = {~mix_o[16], mix_o[15:1]};
	assign acc_sum  = {1'b0, acc} + {1'b0, dac_code};

	// carry out is the pulse density output
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			acc     <= '0;
			audio_o <= 1'b0;
		end else begin
			acc     <= acc_sum[15:0];
			audio_o <= acc_sum[16];
		end
	end

endmodule

/* logic/clock_enables.sv */
// cpu speed latch and clock enables from the slow external clocks
// opl2 and uart clocks are asynchronous to clk_chipset
// they must stay well below half of clk_chipset, each high and low phase
// lasting at least two clk_chipset periods
`timescale 1ns/10ps

module clock_enables (
	input  logic                     clk_chipset,
	input  logic                     reset,
	input  logic                     biu_done_i,
	input  pcxt_support_pkg::speed_t speed_sel_i,
	input  logic                     opl2_clk_i,
	input  logic                     uart_clk_i,
	output pcxt_support_pkg::speed_t speed_o,
	output logic                     turbo_o,
	output logic                     cen_opl2_o,
	output logic                     cen_uart_o
);

	// bit 0 opl2, bit 1 uart
	logic [1:0] sync_1;
	logic [1:0] sync_2;
	logic [1:0] sync_3;
	logic [1:0] cen_r;

	////////////////////
	// speed latch
	////////////////////

	// only between bus cycles so the cpu never sees a torn clock
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			speed_o <= pcxt_support_pkg::SPEED_4_77;
			turbo_o <= 1'b0;
		end else if (biu_done_i) begin
			case (speed_sel_i)
				pcxt_support_pkg::SPEED_7_16,
				pcxt_support_pkg::SPEED_14_318: begin
					speed_o <= speed_sel_i;
					turbo_o <= 1'b1;
				end
				// 4.77 and the unused code
				default: begin
					speed_o <= pcxt_support_pkg::SPEED_4_77;
					turbo_o <= 1'b0;
				end
			endcase
		end
	end

	////////////////////
	// clock enables
	////////////////////

	// two flops for metastability, third for the edge
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_3 <= '0;
			cen_r  <= '0;
		end else begin
			sync_1 <= {uart_clk_i, opl2_clk_i};
			sync_2 <= sync_1;
			sync_3 <= sync_2;
			// rising edge, one clock wide
			cen_r  <= sync_2 & ~sync_3;
		end
	end

	assign cen_opl2_o = cen_r[0];
	assign cen_uart_o = cen_r[1];

endmodule

/* logic/bios_loader.sv */
// rom download to memory through a wishbone classic master
// one byte per bus cycle, the slave ack sets the cycle length
// bytes are taken only with the bus granted, memory ready and system out of reset
// dl_wait_o stays high while a download waits for the bus
// unmapped bytes are dropped with a one-clock wait pulse
`timescale 1ns/10ps

module bios_loader (
	input  logic                       clk_chipset,
	input  logic                       reset,
	input  logic                       sys_reset_i,
	input  pcxt_support_pkg::dl_port_t dl_i,
	output logic                       dl_wait_o,
	input  logic                       mem_ready_i,
	input  logic                       bus_grant_i,
	output logic                       bus_req_o,
	output pcxt_support_pkg::wb_m2s_t  wb_o,
	input  logic                       wb_ack_i,
	input  logic                       model_tandy_i,
	output logic                       bios_protect_o,
	output logic                       tandy_flag_o
);

	pcxt_support_pkg::loader_state_t state;

	// control flops
	logic cyc_r;
	logic busy_r;
	logic req_r;

	// held bus cycle payload
	pcxt_support_pkg::mem_addr_t adr_r;
	pcxt_support_pkg::mem_data_t dat_r;
	logic                        tandy_r;

	// address decode of the current byte
	logic                        low_64k;
	logic                        sel_pcxt;
	logic                        sel_tandy;
	logic                        sel_xtide;
	logic                        mapped;
	logic                        accept;
	pcxt_support_pkg::mem_addr_t map_addr;

	////////////////////
	// address map
	////////////////////

	// main bios images fit in the top 64k
	assign low_64k   = (dl_i.addr[24:16] == 9'd0);
	assign sel_pcxt  = (dl_i.index <= pcxt_support_pkg::IDX_PCXT_LAST) && low_64k;
	assign sel_tandy = (dl_i.index == pcxt_support_pkg::IDX_TANDY) && low_64k;
	// ec00 option rom, 16k window
	assign sel_xtide = (dl_i.index == pcxt_support_pkg::IDX_XTIDE);
	assign mapped    = sel_pcxt | sel_tandy | sel_xtide;

	always_comb begin
		if (sel_xtide) begin
			map_addr = {pcxt_support_pkg::XTIDE_BASE, dl_i.addr[13:0]};
		end else begin
			map_addr = {pcxt_support_pkg::BIOS_SEG_BASE, dl_i.addr[15:0]};
		end
	end

	// byte taken only when armed and not already waiting
	assign accept = (state == pcxt_support_pkg::LD_ARM) && dl_i.active && dl_i.wr && !busy_r;

	////////////////////
	// loader fsm
	////////////////////

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			state  <= pcxt_support_pkg::LD_IDLE;
			cyc_r  <= 1'b0;
			busy_r <= 1'b0;
			req_r  <= 1'b0;
		end else begin
			// keep the bus while a cycle is still open
			req_r <= dl_i.active | (state != pcxt_support_pkg::LD_IDLE);
			case (state)
				pcxt_support_pkg::LD_IDLE: begin
					busy_r <= 1'b0;
					if (dl_i.active && bus_grant_i && mem_ready_i && !sys_reset_i) begin
						state <= pcxt_support_pkg::LD_ARM;
					end
				end
				pcxt_support_pkg::LD_ARM: begin
					if (!dl_i.active || sys_reset_i) begin
						busy_r <= 1'b0;
						state  <= pcxt_support_pkg::LD_IDLE;
					end else if (accept && mapped) begin
						// start the write
						cyc_r  <= 1'b1;
						busy_r <= 1'b1;
						state  <= pcxt_support_pkg::LD_WRITE;
					end else begin
						// unmapped byte gives a single wait clock
						busy_r <= accept;
					end
				end
				pcxt_support_pkg::LD_WRITE: begin
					// cycle ends on the first ack
					if (wb_ack_i) begin
						cyc_r <= 1'b0;
						state <= pcxt_support_pkg::LD_GAP;
					end
				end
				pcxt_support_pkg::LD_GAP: begin
					busy_r <= 1'b0;
					if (dl_i.active) begin
						state <= pcxt_support_pkg::LD_ARM;
					end else begin
						state <= pcxt_support_pkg::LD_IDLE;
					end
				end
				default: begin
					cyc_r  <= 1'b0;
					busy_r <= 1'b0;
					state  <= pcxt_support_pkg::LD_IDLE;
				end
			endcase
		end
	end

	// payload loads with the accepted byte
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			adr_r   <= '0;
			dat_r   <= '0;
			tandy_r <= 1'b0;
		end else if (accept && mapped) begin
			adr_r   <= map_addr;
			dat_r   <= dl_i.data;
			tandy_r <= sel_tandy;
		end
	end

	////////////////////
	// outputs
	////////////////////

	// cyc, stb and we move together
	assign wb_o = '{cyc: cyc_r, stb: cyc_r, we: cyc_r, adr: adr_r, dat: dat_r};

	// hold off the channel while waiting for the bus
	assign dl_wait_o = busy_r | ((state == pcxt_support_pkg::LD_IDLE) & dl_i.active);
	assign bus_req_o = req_r;

	// rom writable for the whole download
	assign bios_protect_o = (state == pcxt_support_pkg::LD_IDLE);
	// tandy tag only during its own write cycle
	assign tandy_flag_o = cyc_r ? tandy_r : model_tandy_i;

endmodule

/* logic/reset_sequencer.sv */
// system and cpu reset generation for the pc/xt core
// sources are the async reset input and the menu reset request
// reset_req is sampled on clk_chipset, so a pulse must last one clock
// model select is only taken while the system reset is high
`timescale 1ns/10ps

module reset_sequencer (
	input  logic                         clk_chipset,
	input  logic                         reset,
	input  pcxt_support_pkg::board_cfg_t cfg_i,
	output logic                         sys_reset_o,
	output logic                         cpu_reset_o,
	output logic                         model_tandy_o
);

	// stretch and delay counters
	logic [15:0] stretch_cnt;
	logic [7:0]  delay_cnt;

	////////////////////
	// system reset
	////////////////////

	// any source restarts the count
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			sys_reset_o <= 1'b1;
			stretch_cnt <= '0;
		end else if (cfg_i.reset_req) begin
			sys_reset_o <= 1'b1;
			stretch_cnt <= '0;
		end else if (sys_reset_o) begin
			// release on the last count
			if (stretch_cnt == pcxt_support_pkg::RESET_STRETCH_CYCLES - 16'd1) begin
				sys_reset_o <= 1'b0;
			end else begin
				stretch_cnt <= stretch_cnt + 16'd1;
			end
		end
	end

	////////////////////
	// cpu reset
	////////////////////

	// held with system reset or a new request, then a fixed delay
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			cpu_reset_o <= 1'b1;
			delay_cnt   <= '0;
		end else if (sys_reset_o || cfg_i.reset_req) begin
			cpu_reset_o <= 1'b1;
			delay_cnt   <= '0;
		end else if (cpu_reset_o) begin
			if (delay_cnt == pcxt_support_pkg::CPU_RESET_DELAY - 8'd1) begin
				cpu_reset_o <= 1'b0;
			end else begin
				delay_cnt <= delay_cnt + 8'd1;
			end
		end
	end

	// model latch
	// frozen once the machine runs, video and bios mapping depend on it
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			model_tandy_o <= 1'b0;
		end else if (sys_reset_o) begin
			model_tandy_o <= cfg_i.model_tandy;
		end
	end

endmodule

/* logic/pcxt_support_pkg.sv */
// shared widths, constants and bus types for the pc/xt board-support logic
// every module refers to these by scoped names
// reset stretch is far shorter than on a real board, long enough for sim
// download indices follow the rom slots of the menu, 0 to 3 only
package pcxt_support_pkg;

	////////////////////
	// vector types
	////////////////////

	// 8088 physical address and memory byte
	typedef logic [19:0] mem_addr_t;
	typedef logic [7:0]  mem_data_t;
	// download offset and slot index
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;
	// cpu speed code
	typedef logic [1:0]  speed_t;
	// audio sources and mixer sum
	typedef logic signed [15:0] opl_sample_t;
	typedef logic [7:0]  tandy_sample_t;
	typedef logic [16:0] mix_t;

	////////////////////
	// constants
	////////////////////

	// clocks after the last reset source
	localparam logic [15:0] RESET_STRETCH_CYCLES = 16'd1024;
	// clocks from system reset release to cpu reset release
	localparam logic [7:0] CPU_RESET_DELAY = 8'd43;

	// upper address bits of the rom windows
	localparam logic [3:0] BIOS_SEG_BASE = 4'hF;
	localparam logic [5:0] XTIDE_BASE = 6'b111011;

	// download slots, 0 and 1 both pc/xt
	localparam dl_index_t IDX_PCXT_LAST = 8'd1;
	localparam dl_index_t IDX_TANDY = 8'd2;
	localparam dl_index_t IDX_XTIDE = 8'd3;

	// speed codes, 3 falls back to 4.77
	localparam speed_t SPEED_4_77 = 2'd0;
	localparam speed_t SPEED_7_16 = 2'd1;
	localparam speed_t SPEED_14_318 = 2'd2;

	// speaker weight in the mix, 2^14
	localparam mix_t SPEAKER_LEVEL = 17'h04000;

	////////////////////
	// fsm and bundles
	////////////////////

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_ARM,
		LD_WRITE,
		LD_GAP
	} loader_state_t;

	// rom download channel
	typedef struct packed {
		logic      active;
		dl_index_t index;
		dl_addr_t  addr;
		mem_data_t data;
		logic      wr;
	} dl_port_t;

	// wishbone classic master outputs
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		mem_addr_t adr;
		mem_data_t dat;
	} wb_m2s_t;

	// board configuration from the menu
	typedef struct packed {
		logic   reset_req;
		logic   model_tandy;
		speed_t cpu_speed;
	} board_cfg_t;

endpackage
